// ==== exec_pipeline.f ====
hdl/exec_pkg.sv
hdl/register_file.sv
hdl/operand_stage.sv
hdl/serial_divider.sv
hdl/exec_stage.sv
hdl/exec_pipeline.sv
dv/exec_pipeline_properties.sv
dv/exec_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exec_pipeline testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f exec_pipeline.f \
    --top-module exec_pipeline_tb -o exec_pipeline_sim &&
./obj_dir/exec_pipeline_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== dv/exec_pipeline_cases.txt ====
# kind opcode dr sr1 sr2 jmp_cond offset exp1 exp2, all hex
# w/c writeback (exp1 reg, exp2 value), b branch (exp1 taken, exp2 target), n none, x squashed
w e 1 0 0 0 0 1 4
w d 2 0 0 0 0 2 fffffffc
w 9 3 0 0 0 0 3 ffffffff
w e 4 0 1 0 0 4 8
w a 5 1 4 0 0 5 400
w 1 6 5 3 0 0 6 3ff
w 2 7 1 4 0 0 7 fffffffc
w 8 8 6 2 0 0 8 3fc
w 6 9 5 1 0 0 9 404
w 7 a 6 5 0 0 a 7ff
w b b 3 1 0 0 b fffffff
w 5 c 2 1 0 0 c ffffffff
w a d 3 5 0 0 d 0
w 5 e 2 5 0 0 e ffffffff
c 1 1 1 1 0 0 1 8
c 1 1 1 1 0 0 1 10
c 2 2 1 4 0 0 2 8
c 7 3 2 1 0 0 3 18
w 3 d 6 a 0 0 d 1ff401
c 1 f d 1 0 0 f 1ff411
w 3 e 7 5 0 0 e fffff000
w 17 f e 1 0 0 f ffffff00
w 18 d e 1 0 0 d fffff00
w 17 c 5 0 0 0 c ffffffff
w 17 a e 7 0 0 a 400
w 18 8 5 a 0 0 8 1
c b 8 c 8 0 0 8 7fffffff
n 2 0 1 1 0 0 0 0
b c 0 5 0 4 20 1 420
x 1 1 1 1 0 0 0 0
b c 0 5 0 5 20 0 420
b c 0 5 0 8 20 1 420
x 1 1 1 1 0 0 0 0
b c 0 5 0 9 20 0 420
n 2 0 2 1 0 0 0 0
b c 0 9 0 6 100 1 504
x 1 1 1 1 0 0 0 0
b c 0 9 0 a 100 1 504
x 1 1 1 1 0 0 0 0
b c 0 9 0 d 100 0 504
n 1 0 8 8 0 0 0 0
b c 0 3 0 0 8 1 20
x 1 1 1 1 0 0 0 0
b c 0 3 0 1 8 0 20
b c 0 3 0 d 8 1 20
x 1 1 1 1 0 0 0 0
b c 0 f 0 f 4 1 ffffff04
x 1 1 1 1 0 0 0 0

// ==== dv/exec_pipeline_tb.sv ====
`default_nettype none

module exec_pipeline_tb;
    import exec_pkg::*;

    logic      clk;
    logic      reset;
    opcode_e   opcode;
    reg_idx_t  dr;
    reg_idx_t  sr1;
    reg_idx_t  sr2;
    jmp_cond_e jmp_cond;
    word_t     offset;
    logic      stall;
    logic      ld_newpc;
    word_t     br_pc;
    reg_idx_t  wb_reg;
    word_t     wb_val;

    string     cases [$];
    reg_idx_t  exp_reg [$];   // Writebacks still to come, in order
    word_t     exp_val [$];
    int        cycles = 0;
    int        limit = 0;
    logic      br_pending = 1'b0;
    logic      br_taken;
    word_t     br_target;

    exec_pipeline dut_i (
        .i_clk(clk), .i_reset(reset), .i_opcode(opcode), .i_dr(dr), .i_sr1(sr1),
        .i_sr2(sr2), .i_jmp_cond(jmp_cond), .i_offset(offset), .o_stall(stall),
        .o_ld_newpc(ld_newpc), .o_br_pc(br_pc), .o_wb_reg(wb_reg), .o_wb_val(wb_val)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_wb(input reg_idx_t got_reg, input word_t got_val,
                            input reg_idx_t want_reg, input word_t want_val);
        if (got_reg !== want_reg || got_val !== want_val)
            stop_with_failure($sformatf("Mismatch at %0t: writeback r%0d=%h, expected r%0d=%h",
                                        $time, got_reg, got_val, want_reg, want_val));
    endtask

    task automatic check_branch(input logic got_taken, input word_t got_pc,
                                input logic want_taken, input word_t want_pc);
        if (got_taken !== want_taken || got_pc !== want_pc)
            stop_with_failure($sformatf("Mismatch at %0t: branch taken=%b pc=%h, expected %b %h",
                                        $time, got_taken, got_pc, want_taken, want_pc));
    endtask

    // Drive on a rising edge, hold through stall, return on the capture edge
    task automatic issue(input logic [31:0] op, input logic [31:0] d, input logic [31:0] s1,
                         input logic [31:0] s2, input logic [31:0] jc, input logic [31:0] off);
        opcode   <= opcode_e'(op[4:0]);
        dr       <= d[3:0];
        sr1      <= s1[3:0];
        sr2      <= s2[3:0];
        jmp_cond <= jmp_cond_e'(jc[3:0]);
        offset   <= off;
        do begin
            @(negedge clk);
            if (br_pending) begin  // Previous branch sits in the buffer now
                check_branch(ld_newpc, br_pc, br_taken, br_target);
                br_pending = 1'b0;
            end
        end while (stall);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit)
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
    end

    // Writeback monitor
    always @(negedge clk) begin
        if (!reset && wb_reg != '0) begin
            if (exp_reg.size() == 0)
                stop_with_failure($sformatf("Unexpected writeback to r%0d at time %0t",
                                            wb_reg, $time));
            else
                check_wb(wb_reg, wb_val, exp_reg.pop_front(), exp_val.pop_front());
        end
    end

    initial begin
        int          fd;
        int          gap;
        string       line;
        string       kind;
        logic [31:0] f_op, f_dr, f_s1, f_s2, f_jc, f_off, f_e1, f_e2;

        void'($urandom(32'hfe52));
        reset    = 1'b1;
        opcode   = op_nop;
        dr       = '0;
        sr1      = '0;
        sr2      = '0;
        jmp_cond = jc_jo;
        offset   = '0;
        fd = $fopen("dv/exec_pipeline_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the case file dv/exec_pipeline_cases.txt");
        end else begin
            while ($fgets(line, fd) != 0)
                if (line.len() > 1 && line.getc(0) != "#")
                    cases.push_back(line);
            $fclose(fd);
            limit = cases.size() * 40 + 100;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            if (stall !== 1'b0 || ld_newpc !== 1'b0 || wb_reg !== '0)
                stop_with_failure("Outputs were not cleared after reset");
            @(posedge clk);
            foreach (cases[i]) begin
                void'($sscanf(cases[i], "%s %h %h %h %h %h %h %h %h", kind, f_op, f_dr,
                              f_s1, f_s2, f_jc, f_off, f_e1, f_e2));
                if (kind == "w" || kind == "n") begin
                    gap = $urandom % 3;  // Idle nops
                    repeat (gap) issue(0, 0, 0, 0, 0, 0);
                end
                if (kind == "w" || kind == "c") begin
                    exp_reg.push_back(f_e1[3:0]);
                    exp_val.push_back(f_e2);
                end
                issue(f_op, f_dr, f_s1, f_s2, f_jc, f_off);
                if (kind == "b") begin  // Checked while the next instruction is issued
                    br_taken   = f_e1[0];
                    br_target  = f_e2;
                    br_pending = 1'b1;
                end
            end
            while (exp_reg.size() != 0 || br_pending)
                issue(0, 0, 0, 0, 0, 0);
            repeat (2) issue(0, 0, 0, 0, 0, 0);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/exec_pipeline_properties.sv ====
`default_nettype none

module exec_pipeline_properties #(
    parameter int MUL_CYCLES = 5
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  wire                 i_ld_newpc,
    input  exec_pkg::reg_idx_t  i_wb_reg,
    input  exec_pkg::opcode_e   i_buf_opcode,
    input  exec_pkg::reg_idx_t  i_buf_dr
);
    import exec_pkg::*;

    // A taken branch leaves nothing in writeback
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_ld_newpc |=> i_wb_reg == '0)
        else $error("Branch cycle was followed by a writeback");

    // Multiply entering the buffer releases the stall after its wait
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_buf_opcode == op_mul && !$past(i_stall)) |-> ##MUL_CYCLES !i_stall)
        else $error("Multiply stall did not fall in time");

    assert property (@(posedge i_clk) disable iff (i_reset)
        i_ld_newpc |=> (i_buf_opcode == op_nop && i_buf_dr == '0))
        else $error("Operand buffer not squashed after taken branch");

endmodule

bind exec_pipeline exec_pipeline_properties #(.MUL_CYCLES(MUL_CYCLES)) props_i (
    .i_clk(i_clk), .i_reset(i_reset), .i_stall(o_stall), .i_ld_newpc(o_ld_newpc),
    .i_wb_reg(o_wb_reg), .i_buf_opcode(buf_opcode), .i_buf_dr(buf_dr)
);

`default_nettype wire

// ==== hdl/exec_pipeline.sv ====
`default_nettype none

module exec_pipeline #(
    parameter int MUL_CYCLES = 5
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  exec_pkg::opcode_e   i_opcode,
    input  exec_pkg::reg_idx_t  i_dr,
    input  exec_pkg::reg_idx_t  i_sr1,
    input  exec_pkg::reg_idx_t  i_sr2,
    input  exec_pkg::jmp_cond_e i_jmp_cond,
    input  exec_pkg::word_t     i_offset,
    output logic                o_stall,
    output logic                o_ld_newpc,
    output exec_pkg::word_t     o_br_pc,
    output exec_pkg::reg_idx_t  o_wb_reg,
    output exec_pkg::word_t     o_wb_val
);
    import exec_pkg::*;

    logic      flush;
    reg_idx_t  rd_a, rd_b, of_reg;
    word_t     rf_a, rf_b, of_val;
    // Operand buffer
    opcode_e   buf_opcode;
    reg_idx_t  buf_dr;
    jmp_cond_e buf_jmp_cond;
    word_t     buf_sr1_val, buf_sr2_val, buf_offset;
    // Divider link
    logic      div_start, div_signed, div_busy, div_valid;
    word_t     div_a, div_b, div_quotient;

    register_file u_regs (
        .i_clk(i_clk), .i_reset(i_reset), .i_rd_a(rd_a), .i_rd_b(rd_b),
        .o_val_a(rf_a), .o_val_b(rf_b), .i_wr_reg(o_wb_reg), .i_wr_val(o_wb_val)
    );

    operand_stage u_operand (
        .i_clk(i_clk), .i_reset(i_reset), .i_stall(o_stall), .i_flush(flush),
        .i_opcode(i_opcode), .i_dr(i_dr), .i_sr1(i_sr1), .i_sr2(i_sr2),
        .i_jmp_cond(i_jmp_cond), .i_offset(i_offset),
        .o_rd_a(rd_a), .o_rd_b(rd_b), .i_rf_a(rf_a), .i_rf_b(rf_b),
        .i_of_reg(of_reg), .i_of_val(of_val),
        .o_opcode(buf_opcode), .o_dr(buf_dr), .o_jmp_cond(buf_jmp_cond),
        .o_sr1_val(buf_sr1_val), .o_sr2_val(buf_sr2_val), .o_offset(buf_offset)
    );

    exec_stage #(.MUL_CYCLES(MUL_CYCLES)) u_exec (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_opcode(buf_opcode), .i_dr(buf_dr), .i_jmp_cond(buf_jmp_cond),
        .i_sr1_val(buf_sr1_val), .i_sr2_val(buf_sr2_val), .i_offset(buf_offset),
        .o_stall(o_stall), .o_flush(flush), .o_of_reg(of_reg), .o_of_val(of_val),
        .o_dr(o_wb_reg), .o_value(o_wb_val), .o_ld_newpc(o_ld_newpc), .o_br_pc(o_br_pc),
        .o_div_start(div_start), .o_div_signed(div_signed), .o_div_a(div_a),
        .o_div_b(div_b), .i_div_busy(div_busy), .i_div_valid(div_valid),
        .i_div_quotient(div_quotient)
    );

    serial_divider u_div (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(div_start), .i_signed(div_signed),
        .i_dividend(div_a), .i_divisor(div_b), .o_busy(div_busy),
        .o_valid(div_valid), .o_quotient(div_quotient)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`default_nettype none

module exec_stage #(
    parameter int MUL_CYCLES = 5
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    // Operand buffer
    input  exec_pkg::opcode_e   i_opcode,
    input  exec_pkg::reg_idx_t  i_dr,
    input  exec_pkg::jmp_cond_e i_jmp_cond,
    input  exec_pkg::word_t     i_sr1_val,
    input  exec_pkg::word_t     i_sr2_val,
    input  exec_pkg::word_t     i_offset,
    output logic                o_stall,
    output logic                o_flush,
    // Bypass
    output exec_pkg::reg_idx_t  o_of_reg,
    output exec_pkg::word_t     o_of_val,
    // Result register
    output exec_pkg::reg_idx_t  o_dr,
    output exec_pkg::word_t     o_value,
    output logic                o_ld_newpc,
    output exec_pkg::word_t     o_br_pc,
    // Divider link
    output logic                o_div_start,
    output logic                o_div_signed,
    output exec_pkg::word_t     o_div_a,
    output exec_pkg::word_t     o_div_b,
    input  wire                 i_div_busy,
    input  wire                 i_div_valid,
    input  exec_pkg::word_t     i_div_quotient
);
    import exec_pkg::*;

    localparam int MW = $clog2(MUL_CYCLES + 1);

    alu_op_e       alu_op;
    logic          is_branch;
    logic          is_div;
    logic          set_flags;
    logic          carry;
    logic          overflow;
    logic          done;     // Result completes this cycle
    logic          do_jump;
    logic          div_pending;
    logic [MW-1:0] mul_wait;
    logic          big_shift;
    logic [4:0]    shamt;
    word_t         alu_result;
    word_t         mul_product;
    flags_t        flags;
    flags_t        new_flags;

    always_comb begin
        case (i_opcode)
            op_add:  alu_op = alu_add;
            op_sub:  alu_op = alu_sub;
            op_and:  alu_op = alu_and;
            op_or:   alu_op = alu_or;
            op_xor:  alu_op = alu_xor;
            op_not:  alu_op = alu_not;
            op_call: alu_op = alu_dec4;
            op_ret:  alu_op = alu_inc4;
            op_shl:  alu_op = alu_shl;
            op_shr:  alu_op = alu_shr;
            op_shra: alu_op = alu_shra;
            op_mul:  alu_op = alu_mul;
            op_div:  alu_op = alu_div;
            op_udiv: alu_op = alu_udiv;
            default: alu_op = alu_nop;  // Branch lands here too
        endcase
    end

    assign is_branch   = (i_opcode == op_branch);
    assign is_div      = (alu_op == alu_div) || (alu_op == alu_udiv);
    assign mul_product = i_sr1_val * i_sr2_val;  // Low 32 bits only
    assign shamt       = i_sr2_val[4:0];
    assign big_shift   = |i_sr2_val[31:5];

    always_comb begin
        carry      = 1'b0;
        alu_result = i_sr1_val;
        case (alu_op)
            alu_add:  {carry, alu_result} = {1'b0, i_sr1_val} + {1'b0, i_sr2_val};
            alu_sub:  {carry, alu_result} = {1'b0, i_sr1_val} - {1'b0, i_sr2_val};  // Borrow
            alu_and:  alu_result = i_sr1_val & i_sr2_val;
            alu_or:   alu_result = i_sr1_val | i_sr2_val;
            alu_xor:  alu_result = i_sr1_val ^ i_sr2_val;
            alu_not:  alu_result = ~i_sr1_val;
            alu_inc4: alu_result = i_sr2_val + 32'd4;
            alu_dec4: alu_result = i_sr2_val - 32'd4;
            alu_shl:  alu_result = big_shift ? '0 : i_sr1_val << shamt;
            alu_shr:  alu_result = big_shift ? '0 : i_sr1_val >> shamt;
            alu_shra: alu_result = big_shift ? {32{i_sr1_val[31]}}
                                             : word_t'($signed(i_sr1_val) >>> shamt);
            alu_mul:  alu_result = mul_product;
            alu_div, alu_udiv: alu_result = i_div_quotient;
            default:  alu_result = i_sr1_val;
        endcase
    end

    // Signed overflow, add and sub only
    always_comb begin
        if (alu_op == alu_add)
            overflow = (i_sr1_val[31] == i_sr2_val[31]) && (alu_result[31] != i_sr1_val[31]);
        else if (alu_op == alu_sub)
            overflow = (i_sr1_val[31] != i_sr2_val[31]) && (alu_result[31] != i_sr1_val[31]);
        else
            overflow = 1'b0;
    end

    always_comb begin
        case (alu_op)
            alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_not: set_flags = 1'b1;
            default: set_flags = 1'b0;
        endcase
        new_flags.overflow = overflow;
        new_flags.zero     = (alu_result == '0);
        new_flags.carry    = carry;
        new_flags.sign     = alu_result[31];
    end

    // Condition check uses the stored flags
    always_comb begin
        case (i_jmp_cond)
            jc_jo:   do_jump = flags.overflow;
            jc_jno:  do_jump = !flags.overflow;
            jc_js:   do_jump = flags.sign;
            jc_jns:  do_jump = !flags.sign;
            jc_je:   do_jump = flags.zero;
            jc_jne:  do_jump = !flags.zero;
            jc_jb:   do_jump = flags.carry;
            jc_jnb:  do_jump = !flags.carry;
            jc_jbe:  do_jump = flags.carry || flags.zero;
            jc_ja:   do_jump = !flags.carry && !flags.zero;
            jc_jl:   do_jump = flags.sign ^ flags.overflow;
            jc_jge:  do_jump = flags.sign == flags.overflow;
            jc_jle:  do_jump = flags.zero || (flags.sign ^ flags.overflow);
            jc_jg:   do_jump = !flags.zero && (flags.sign == flags.overflow);
            default: do_jump = 1'b1;
        endcase
    end

    assign o_ld_newpc = is_branch && do_jump;
    assign o_flush    = o_ld_newpc;
    assign o_br_pc    = i_sr1_val + i_offset;

    always_comb begin
        case (alu_op)
            alu_nop:           done = 1'b0;
            alu_mul:           done = (mul_wait == MW'(MUL_CYCLES));
            alu_div, alu_udiv: done = i_div_valid;
            default:           done = 1'b1;
        endcase
    end

    assign o_stall  = (alu_op == alu_mul || is_div) && !done;
    assign o_of_reg = done ? i_dr : '0;
    assign o_of_val = done ? alu_result : '0;

    // One start per divide instruction
    assign o_div_start  = is_div && !div_pending && !i_div_busy;
    assign o_div_signed = (alu_op == alu_div);
    assign o_div_a      = i_sr1_val;
    assign o_div_b      = i_sr2_val;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_dr        <= '0;
            o_value     <= '0;
            flags       <= '0;
            mul_wait    <= '0;
            div_pending <= 1'b0;
        end else begin
            o_dr    <= o_of_reg;
            o_value <= o_of_val;
            if (set_flags)
                flags <= new_flags;
            if (alu_op == alu_mul && !done)
                mul_wait <= mul_wait + 1'b1;
            else
                mul_wait <= '0;
            if (o_div_start)
                div_pending <= 1'b1;
            else if (i_div_valid)
                div_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/serial_divider.sv ====
`default_nettype none

module serial_divider (
    input  wire             i_clk,
    input  wire             i_reset,
    input  wire             i_start,
    input  wire             i_signed,
    input  exec_pkg::word_t i_dividend,
    input  exec_pkg::word_t i_divisor,
    output logic            o_busy,
    output logic            o_valid,
    output exec_pkg::word_t o_quotient
);
    import exec_pkg::*;

    word_t       quot;       // Dividend shifts out, quotient bits shift in
    word_t       rem;
    word_t       divisor;
    logic        negate;
    logic [4:0]  count;
    logic [32:0] rem_shift;
    logic [32:0] trial;
    word_t       abs_dividend;
    word_t       abs_divisor;

    always_comb begin
        abs_dividend = (i_signed && i_dividend[31]) ? -i_dividend : i_dividend;
        abs_divisor  = (i_signed && i_divisor[31]) ? -i_divisor : i_divisor;
    end

    // One restoring step
    assign rem_shift = {rem, quot[31]};
    assign trial     = rem_shift - {1'b0, divisor};

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy  <= 1'b0;
            o_valid <= 1'b0;
            count   <= '0;
        end else begin
            o_valid <= 1'b0;
            if (i_start && !o_busy) begin
                o_busy <= 1'b1;
                count  <= '0;
            end else if (o_busy) begin
                count <= count + 1'b1;
                if (count == 5'd31) begin  // Last iteration
                    o_busy  <= 1'b0;
                    o_valid <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge i_clk) begin
        if (i_start && !o_busy) begin
            quot    <= abs_dividend;
            rem     <= '0;
            divisor <= abs_divisor;
            // Zero divisor keeps the all-ones quotient unsigned
            negate  <= i_signed && (i_divisor != '0) && (i_dividend[31] ^ i_divisor[31]);
        end else if (o_busy) begin
            if (!trial[32]) begin
                rem  <= trial[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= rem_shift[31:0];
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    assign o_quotient = negate ? -quot : quot;

endmodule

`default_nettype wire

// ==== hdl/operand_stage.sv ====
`default_nettype none

module operand_stage (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  wire                 i_flush,
    // Issue port
    input  exec_pkg::opcode_e   i_opcode,
    input  exec_pkg::reg_idx_t  i_dr,
    input  exec_pkg::reg_idx_t  i_sr1,
    input  exec_pkg::reg_idx_t  i_sr2,
    input  exec_pkg::jmp_cond_e i_jmp_cond,
    input  exec_pkg::word_t     i_offset,
    // Register file reads
    output exec_pkg::reg_idx_t  o_rd_a,
    output exec_pkg::reg_idx_t  o_rd_b,
    input  exec_pkg::word_t     i_rf_a,
    input  exec_pkg::word_t     i_rf_b,
    // Bypass from execute
    input  exec_pkg::reg_idx_t  i_of_reg,
    input  exec_pkg::word_t     i_of_val,
    // Stage buffer
    output exec_pkg::opcode_e   o_opcode,
    output exec_pkg::reg_idx_t  o_dr,
    output exec_pkg::jmp_cond_e o_jmp_cond,
    output exec_pkg::word_t     o_sr1_val,
    output exec_pkg::word_t     o_sr2_val,
    output exec_pkg::word_t     o_offset
);
    import exec_pkg::*;

    word_t sr1_val;
    word_t sr2_val;

    assign o_rd_a = i_sr1;
    assign o_rd_b = i_sr2;

    // Result still in execute wins over the register file
    always_comb begin
        if (i_of_reg != '0 && i_of_reg == i_sr1)
            sr1_val = i_of_val;
        else
            sr1_val = i_rf_a;
        if (i_of_reg != '0 && i_of_reg == i_sr2)
            sr2_val = i_of_val;
        else
            sr2_val = i_rf_b;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            // Squashed slot becomes a nop
            o_opcode   <= op_nop;
            o_dr       <= '0;
            o_jmp_cond <= jc_jo;
            o_sr1_val  <= '0;
            o_sr2_val  <= '0;
            o_offset   <= '0;
        end else if (!i_stall) begin
            o_opcode   <= i_opcode;
            o_dr       <= i_dr;
            o_jmp_cond <= i_jmp_cond;
            o_sr1_val  <= sr1_val;
            o_sr2_val  <= sr2_val;
            o_offset   <= i_offset;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`default_nettype none

module register_file (
    input  wire               i_clk,
    input  wire               i_reset,
    input  exec_pkg::reg_idx_t i_rd_a,
    input  exec_pkg::reg_idx_t i_rd_b,
    output exec_pkg::word_t    o_val_a,
    output exec_pkg::word_t    o_val_b,
    input  exec_pkg::reg_idx_t i_wr_reg,
    input  exec_pkg::word_t    i_wr_val
);
    import exec_pkg::*;

    word_t regs [1:15];  // Register 0 has no storage

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 16; i++)
                regs[i] <= '0;
        end else if (i_wr_reg != '0) begin
            regs[i_wr_reg] <= i_wr_val;
        end
    end

    // Same-cycle write is seen by the reads
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (idx == i_wr_reg)
            return i_wr_val;
        else
            return regs[idx];
    endfunction

    always_comb begin
        o_val_a = read_port(i_rd_a);
        o_val_b = read_port(i_rd_b);
    end

endmodule

`default_nettype wire

// ==== hdl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;  // 0 means no register

    // Instruction opcodes as issued
    typedef enum logic [4:0] {
        op_nop    = 5'd0,
        op_add    = 5'd1,
        op_sub    = 5'd2,
        op_mul    = 5'd3,
        op_shra   = 5'd5,
        op_or     = 5'd6,
        op_xor    = 5'd7,
        op_and    = 5'd8,
        op_not    = 5'd9,
        op_shl    = 5'd10,
        op_shr    = 5'd11,
        op_branch = 5'd12,
        op_call   = 5'd13,
        op_ret    = 5'd14,
        op_div    = 5'd23,
        op_udiv   = 5'd24
    } opcode_e;

    // Internal ALU operations decoded in the execute stage
    typedef enum logic [3:0] {
        alu_nop, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_not,
        alu_inc4, alu_dec4, alu_shl, alu_shr, alu_shra,
        alu_mul, alu_div, alu_udiv
    } alu_op_e;

    typedef enum logic [3:0] {
        jc_jo, jc_jno, jc_js, jc_jns, jc_je, jc_jne, jc_jb, jc_jnb,
        jc_jbe, jc_ja, jc_jl, jc_jge, jc_jle, jc_jg,
        jc_jmp = 4'd15  // Unconditional
    } jmp_cond_e;

    typedef struct packed {
        logic overflow;
        logic zero;
        logic carry;
        logic sign;
    } flags_t;

endpackage

`default_nettype wire
